// ==== hw/bridge_pkg.sv ====
package bridge_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int addr_w  = 32;
  localparam int data_w  = 32;
  localparam int coord_w = 4;

  // word address inside a tile, taken from addr[19:2]
  localparam int epa_w = 18;

  // upper bound on the tag carried in packets and returns
  localparam int max_tag_w = 4;

  ////////////////////
  // address fields
  ////////////////////
  // set for tile traffic, clear for the host at (0,0)
  localparam int tile_sel_bit = 31;
  localparam int tile_y_lsb   = 24;
  localparam int tile_x_lsb   = 20;

  ////////////////////
  // encodings
  ////////////////////
  typedef enum logic [1:0]
  {
    size_1 = 2'd0,
    size_2 = 2'd1,
    size_4 = 2'd2
  } msg_size_e;

  typedef enum logic [1:0]
  {
    op_load         = 2'd0,
    op_store_word   = 2'd1,
    op_store_masked = 2'd2
  } pkt_op_e;

endpackage

// ==== hw/tag_alloc_if.sv ====
`timescale 1ns/1ps

interface tag_alloc_if
  #(parameter int max_outstanding_p = 4);

  import bridge_pkg::*;

  localparam int tag_w = $clog2(max_outstanding_p);

  // free slot, offered by the buffer
  logic             alloc_avail;
  logic [tag_w-1:0] alloc_tag;

  // header written into the slot on take
  logic              alloc_take;
  logic              hdr_write;
  msg_size_e         hdr_size;
  logic [addr_w-1:0] hdr_addr;

  modport issuer
  (
    input  alloc_avail, alloc_tag,
    output alloc_take, hdr_write, hdr_size, hdr_addr
  );

  modport buffer
  (
    output alloc_avail, alloc_tag,
    input  alloc_take, hdr_write, hdr_size, hdr_addr
  );

endinterface

// ==== hw/resp_entry_if.sv ====
`timescale 1ns/1ps

interface resp_entry_if;

  import bridge_pkg::*;

  // head entry of the reorder buffer, in command order
  logic              ent_valid;
  logic              ent_ready;
  logic              ent_write;
  msg_size_e         ent_size;
  logic [addr_w-1:0] ent_addr;
  logic [data_w-1:0] ent_data;

  modport buffer
  (
    output ent_valid, ent_write, ent_size, ent_addr, ent_data,
    input  ent_ready
  );

  modport builder
  (
    input  ent_valid, ent_write, ent_size, ent_addr, ent_data,
    output ent_ready
  );

endinterface

// ==== hw/cmd_issuer.sv ====
`timescale 1ns/1ps

module cmd_issuer
  #(parameter int max_outstanding_p = 4)
  (
    input  logic                                 clk_i,
    input  logic                                 reset_i,

    input  logic                                 cmd_valid_i,
    output logic                                 cmd_ready_o,
    input  logic                                 cmd_write_i,
    input  bridge_pkg::msg_size_e                cmd_size_i,
    input  logic [bridge_pkg::addr_w-1:0]        cmd_addr_i,
    input  logic [bridge_pkg::data_w-1:0]        cmd_data_i,

    output logic                                 pkt_valid_o,
    input  logic                                 pkt_ready_i,
    output bridge_pkg::pkt_op_e                  pkt_op_o,
    output logic [bridge_pkg::coord_w-1:0]       pkt_x_o,
    output logic [bridge_pkg::coord_w-1:0]       pkt_y_o,
    output logic [bridge_pkg::epa_w-1:0]         pkt_epa_o,
    output logic [bridge_pkg::data_w-1:0]        pkt_data_o,
    output logic [3:0]                           pkt_mask_o,
    output logic [bridge_pkg::max_tag_w-1:0]     pkt_tag_o,

    tag_alloc_if.issuer                          alloc
  );

  import bridge_pkg::*;

  localparam int tag_w = $clog2(max_outstanding_p);

  logic [tag_w-1:0] tag;
  logic [1:0]       low_bits;
  logic [3:0]       store_mask;
  logic             to_tile;

  assign tag      = alloc.alloc_tag;
  assign low_bits = cmd_addr_i[1:0];
  assign to_tile  = cmd_addr_i[tile_sel_bit];

  ////////////////////
  // handshake
  ////////////////////
  // command and packet move together when a tag is free
  assign pkt_valid_o = cmd_valid_i & alloc.alloc_avail;
  assign cmd_ready_o = alloc.alloc_avail & pkt_ready_i;

  assign alloc.alloc_take = pkt_valid_o & pkt_ready_i;
  assign alloc.hdr_write  = cmd_write_i;
  assign alloc.hdr_size   = cmd_size_i;
  assign alloc.hdr_addr   = cmd_addr_i;

  ////////////////////
  // route
  ////////////////////
  // host sits at (0,0)
  assign pkt_x_o   = to_tile ? cmd_addr_i[tile_x_lsb +: coord_w] : '0;
  assign pkt_y_o   = to_tile ? cmd_addr_i[tile_y_lsb +: coord_w] : '0;
  assign pkt_epa_o = cmd_addr_i[2 +: epa_w];
  assign pkt_tag_o = max_tag_w'(tag);

  ////////////////////
  // op and mask
  ////////////////////
  always_comb
  begin
    case (cmd_size_i)
      size_1:  store_mask = 4'h1 << low_bits;
      size_2:  store_mask = 4'h3 << low_bits;
      default: store_mask = 4'hf << low_bits;
    endcase
  end

  always_comb
  begin
    if (cmd_write_i)
    begin
      pkt_op_o   = (store_mask == 4'hf) ? op_store_word : op_store_masked;
      pkt_mask_o = store_mask;
      pkt_data_o = cmd_data_i;
    end
    else
    begin
      // part select for the load
      pkt_op_o   = op_load;
      pkt_mask_o = {2'b00, low_bits};
      pkt_data_o = '0;
    end
  end

  // a waiting packet keeps its slot and its tag
  a_wait_keeps_slot: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_valid_o && !pkt_ready_i |=> alloc.alloc_avail && $stable(alloc.alloc_tag));

endmodule

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer
  #(parameter int max_outstanding_p = 4)
  (
    input  logic                             clk_i,
    input  logic                             reset_i,

    input  logic                             ret_valid_i,
    input  logic [bridge_pkg::max_tag_w-1:0] ret_tag_i,
    input  logic [bridge_pkg::data_w-1:0]    ret_data_i,

    tag_alloc_if.buffer                      alloc,
    resp_entry_if.buffer                     ent
  );

  import bridge_pkg::*;

  localparam int tag_w = $clog2(max_outstanding_p);
  localparam int cnt_w = $clog2(max_outstanding_p + 1);

  // slot storage
  logic              hdr_write_r [max_outstanding_p];
  msg_size_e         hdr_size_r  [max_outstanding_p];
  logic [addr_w-1:0] hdr_addr_r  [max_outstanding_p];
  logic [data_w-1:0] data_r      [max_outstanding_p];

  logic [max_outstanding_p-1:0] pending_r;
  logic [max_outstanding_p-1:0] done_r;

  logic [tag_w-1:0] head_r;
  logic [tag_w-1:0] tail_r;
  logic [cnt_w-1:0] count_r;

  logic [tag_w-1:0] ret_slot;
  logic             ent_fire;

  function automatic logic [tag_w-1:0] ptr_next(input logic [tag_w-1:0] ptr);
    if (ptr == tag_w'(max_outstanding_p - 1))
      ptr_next = '0;
    else
      ptr_next = ptr + 1'b1;
  endfunction

  assign ret_slot = ret_tag_i[tag_w-1:0];
  assign ent_fire = ent.ent_valid & ent.ent_ready;

  ////////////////////
  // allocation
  ////////////////////
  assign alloc.alloc_avail = (count_r != cnt_w'(max_outstanding_p));
  assign alloc.alloc_tag   = tail_r;

  ////////////////////
  // in-order release
  ////////////////////
  assign ent.ent_valid = pending_r[head_r] & done_r[head_r];
  assign ent.ent_write = hdr_write_r[head_r];
  assign ent.ent_size  = hdr_size_r[head_r];
  assign ent.ent_addr  = hdr_addr_r[head_r];
  assign ent.ent_data  = data_r[head_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pending_r <= '0;
      done_r    <= '0;
      head_r    <= '0;
      tail_r    <= '0;
      count_r   <= '0;
    end
    else
    begin
      if (alloc.alloc_take)
      begin
        pending_r[tail_r] <= 1'b1;
        done_r[tail_r]    <= 1'b0;
        tail_r            <= ptr_next(tail_r);
      end
      // returns may land in any pending slot
      if (ret_valid_i)
        done_r[ret_slot] <= 1'b1;
      if (ent_fire)
      begin
        pending_r[head_r] <= 1'b0;
        done_r[head_r]    <= 1'b0;
        head_r            <= ptr_next(head_r);
      end
      count_r <= count_r + cnt_w'(alloc.alloc_take) - cnt_w'(ent_fire);
    end
  end

  // header on allocation, data on return
  always_ff @(posedge clk_i)
  begin
    if (alloc.alloc_take)
    begin
      hdr_write_r[tail_r] <= alloc.hdr_write;
      hdr_size_r[tail_r]  <= alloc.hdr_size;
      hdr_addr_r[tail_r]  <= alloc.hdr_addr;
    end
    if (ret_valid_i)
      data_r[ret_slot] <= ret_data_i;
  end

  // the network only answers tags that are out and unanswered
  a_ret_tag_live: assert property (@(posedge clk_i) disable iff (reset_i)
    ret_valid_i |-> (int'(ret_tag_i) < max_outstanding_p)
                    && pending_r[ret_slot] && !done_r[ret_slot]);

  a_ent_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    ent.ent_valid && !ent.ent_ready |=> ent.ent_valid
      && $stable(ent.ent_write) && $stable(ent.ent_size)
      && $stable(ent.ent_addr) && $stable(ent.ent_data));

endmodule

// ==== hw/resp_builder.sv ====
`timescale 1ns/1ps

module resp_builder
  (
    input  logic                          clk_i,
    input  logic                          reset_i,

    resp_entry_if.builder                 ent,

    output logic                          rsp_valid_o,
    input  logic                          rsp_ready_i,
    output logic                          rsp_write_o,
    output bridge_pkg::msg_size_e         rsp_size_o,
    output logic [bridge_pkg::addr_w-1:0] rsp_addr_o,
    output logic [bridge_pkg::data_w-1:0] rsp_data_o
  );

  import bridge_pkg::*;

  logic              full_r;
  logic [data_w-1:0] rsp_data_n;

  // take a new entry when empty or draining this cycle
  assign ent.ent_ready = ~full_r | rsp_ready_i;
  assign rsp_valid_o   = full_r;

  // loads zero-extended to the access size, stores carry no data
  always_comb
  begin
    if (ent.ent_write)
      rsp_data_n = '0;
    else
    begin
      case (ent.ent_size)
        size_1:  rsp_data_n = {{(data_w-8){1'b0}}, ent.ent_data[7:0]};
        size_2:  rsp_data_n = {{(data_w-16){1'b0}}, ent.ent_data[15:0]};
        default: rsp_data_n = ent.ent_data;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      full_r <= 1'b0;
    else if (ent.ent_valid & ent.ent_ready)
      full_r <= 1'b1;
    else if (rsp_ready_i)
      full_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (ent.ent_valid & ent.ent_ready)
    begin
      rsp_write_o <= ent.ent_write;
      rsp_size_o  <= ent.ent_size;
      rsp_addr_o  <= ent.ent_addr;
      rsp_data_o  <= rsp_data_n;
    end
  end

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_write_o)
      && $stable(rsp_size_o) && $stable(rsp_addr_o) && $stable(rsp_data_o));

endmodule

// ==== hw/mem_to_mesh_bridge.sv ====
`timescale 1ns/1ps

module mem_to_mesh_bridge
  #(parameter int max_outstanding_p = 4)
  (
    input  logic                             clk_i,
    input  logic                             reset_i,

    // processor commands
    input  logic                             cmd_valid_i,
    output logic                             cmd_ready_o,
    input  logic                             cmd_write_i,
    input  bridge_pkg::msg_size_e            cmd_size_i,
    input  logic [bridge_pkg::addr_w-1:0]    cmd_addr_i,
    input  logic [bridge_pkg::data_w-1:0]    cmd_data_i,

    // request packets to the mesh
    output logic                             pkt_valid_o,
    input  logic                             pkt_ready_i,
    output bridge_pkg::pkt_op_e              pkt_op_o,
    output logic [bridge_pkg::coord_w-1:0]   pkt_x_o,
    output logic [bridge_pkg::coord_w-1:0]   pkt_y_o,
    output logic [bridge_pkg::epa_w-1:0]     pkt_epa_o,
    output logic [bridge_pkg::data_w-1:0]    pkt_data_o,
    output logic [3:0]                       pkt_mask_o,
    output logic [bridge_pkg::max_tag_w-1:0] pkt_tag_o,

    // returns from the mesh, always accepted
    input  logic                             ret_valid_i,
    input  logic [bridge_pkg::max_tag_w-1:0] ret_tag_i,
    input  logic [bridge_pkg::data_w-1:0]    ret_data_i,

    // responses to the processor
    output logic                             rsp_valid_o,
    input  logic                             rsp_ready_i,
    output logic                             rsp_write_o,
    output bridge_pkg::msg_size_e            rsp_size_o,
    output logic [bridge_pkg::addr_w-1:0]    rsp_addr_o,
    output logic [bridge_pkg::data_w-1:0]    rsp_data_o
  );

  tag_alloc_if #(.max_outstanding_p(max_outstanding_p)) alloc_if ();
  resp_entry_if ent_if ();

  cmd_issuer #(.max_outstanding_p(max_outstanding_p)) u_cmd_issuer
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_write_i (cmd_write_i),
    .cmd_size_i  (cmd_size_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .pkt_valid_o (pkt_valid_o),
    .pkt_ready_i (pkt_ready_i),
    .pkt_op_o    (pkt_op_o),
    .pkt_x_o     (pkt_x_o),
    .pkt_y_o     (pkt_y_o),
    .pkt_epa_o   (pkt_epa_o),
    .pkt_data_o  (pkt_data_o),
    .pkt_mask_o  (pkt_mask_o),
    .pkt_tag_o   (pkt_tag_o),
    .alloc       (alloc_if.issuer)
  );

  reorder_buffer #(.max_outstanding_p(max_outstanding_p)) u_reorder_buffer
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ret_valid_i (ret_valid_i),
    .ret_tag_i   (ret_tag_i),
    .ret_data_i  (ret_data_i),
    .alloc       (alloc_if.buffer),
    .ent         (ent_if.buffer)
  );

  resp_builder u_resp_builder
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ent         (ent_if.builder),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_write_o (rsp_write_o),
    .rsp_size_o  (rsp_size_o),
    .rsp_addr_o  (rsp_addr_o),
    .rsp_data_o  (rsp_data_o)
  );

endmodule

// ==== test/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected responses kept in command order
typedef struct packed
{
  logic                 write;
  msg_size_e            size;
  logic [addr_w-1:0]    addr;
  logic [max_tag_w-1:0] tag;
  logic                 got;
  logic [data_w-1:0]    data;
} exp_rsp_t;

// 32-bit xorshift with shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] roll(inout logic [31:0] state);
  state = xorshift32(state);
  return state;
endfunction

// a lane is written when it falls inside [offset, offset + bytes)
function automatic logic [3:0] lane_mask(input msg_size_e size, input logic [1:0] offset);
  logic [3:0] lanes;
  int         nbytes;
  nbytes = (size == size_1) ? 1 : (size == size_2) ? 2 : 4;
  for (int b = 0; b < 4; b++)
    lanes[b] = (b >= int'(offset)) && (b < int'(offset) + nbytes);
  return lanes;
endfunction

function automatic pkt_op_e packet_op(input logic write, input logic [3:0] lanes);
  if (!write)
    return op_load;
  if (lanes == 4'b1111)
    return op_store_word;
  return op_store_masked;
endfunction

// host traffic always lands on (0,0)
function automatic logic [coord_w-1:0] route_coord(input logic [addr_w-1:0] addr,
                                                   input int lsb);
  if (!addr[tile_sel_bit])
    return '0;
  return coord_w'(addr >> lsb);
endfunction

function automatic logic [data_w-1:0] narrow_load(input msg_size_e size,
                                                  input logic [data_w-1:0] raw);
  case (size)
    size_1:  return raw & 32'h0000_00ff;
    size_2:  return raw & 32'h0000_ffff;
    default: return raw;
  endcase
endfunction

`endif

// ==== test/tb_mem_to_mesh_bridge.sv ====
`timescale 1ns/1ps

module tb_mem_to_mesh_bridge
  #(parameter int max_outstanding_p = 4);

  import bridge_pkg::*;

  `include "tb_model.svh"

  localparam int num_cmds    = 300;
  localparam int accept_wait = 500;
  localparam int drain_wait  = 2000;

  logic                 clk;
  logic                 reset;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 cmd_write;
  msg_size_e            cmd_size;
  logic [addr_w-1:0]    cmd_addr;
  logic [data_w-1:0]    cmd_data;
  logic                 pkt_valid;
  logic                 pkt_ready;
  pkt_op_e              pkt_op;
  logic [coord_w-1:0]   pkt_x;
  logic [coord_w-1:0]   pkt_y;
  logic [epa_w-1:0]     pkt_epa;
  logic [data_w-1:0]    pkt_data;
  logic [3:0]           pkt_mask;
  logic [max_tag_w-1:0] pkt_tag;
  logic                 ret_valid;
  logic [max_tag_w-1:0] ret_tag;
  logic [data_w-1:0]    ret_data;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic                 rsp_write;
  msg_size_e            rsp_size;
  logic [addr_w-1:0]    rsp_addr;
  logic [data_w-1:0]    rsp_data;

  // model state
  logic [31:0]          stim_seed;
  logic [31:0]          net_seed;
  logic [max_tag_w-1:0] pend_q[$];
  exp_rsp_t             exp_q[$];
  int                   errors;
  int                   pkts_seen;
  int                   rsps_seen;
  logic                 saw_full;
  logic                 timed_out;

  mem_to_mesh_bridge #(.max_outstanding_p(max_outstanding_p)) mem_to_mesh_bridge_i
  (
    .clk_i       (clk),
    .reset_i     (reset),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .cmd_write_i (cmd_write),
    .cmd_size_i  (cmd_size),
    .cmd_addr_i  (cmd_addr),
    .cmd_data_i  (cmd_data),
    .pkt_valid_o (pkt_valid),
    .pkt_ready_i (pkt_ready),
    .pkt_op_o    (pkt_op),
    .pkt_x_o     (pkt_x),
    .pkt_y_o     (pkt_y),
    .pkt_epa_o   (pkt_epa),
    .pkt_data_o  (pkt_data),
    .pkt_mask_o  (pkt_mask),
    .pkt_tag_o   (pkt_tag),
    .ret_valid_i (ret_valid),
    .ret_tag_i   (ret_tag),
    .ret_data_i  (ret_data),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_write_o (rsp_write),
    .rsp_size_o  (rsp_size),
    .rsp_addr_o  (rsp_addr),
    .rsp_data_o  (rsp_data)
  );

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("error at %0t: %s got %h expected %h", $time, what, got, want);
    errors++;
  endtask

  // store the returned data in the one unanswered entry with this tag
  task automatic fill_return(input logic [max_tag_w-1:0] tag, input logic [data_w-1:0] data);
    exp_rsp_t entry;
    for (int i = 0; i < exp_q.size(); i++)
    begin
      entry = exp_q[i];
      if (entry.tag == tag && !entry.got)
      begin
        entry.got  = 1'b1;
        entry.data = data;
        exp_q[i]   = entry;
        break;
      end
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // network and processor side
  ////////////////////
  initial
  begin : network_side
    logic [31:0] r;
    logic        live;
    int          pick;
    pkt_ready = 1'b1;
    rsp_ready = 1'b0;
    ret_valid = 1'b0;
    ret_tag   = '0;
    ret_data  = '0;
    forever
    begin
      @(posedge clk);
      live = !reset;
      #1;
      ret_valid = 1'b0;
      if (live)
      begin
        r = roll(net_seed);
        pkt_ready = (r[1:0] != 2'b00);
        rsp_ready = r[2];
        // answer a pending tag picked at random
        if (pend_q.size() > 0 && r[4:3] == 2'b00)
        begin
          pick      = int'(r[15:8]) % pend_q.size();
          ret_tag   = pend_q[pick];
          pend_q.delete(pick);
          ret_data  = roll(net_seed);
          ret_valid = 1'b1;
          fill_return(ret_tag, ret_data);
        end
      end
    end
  end

  ////////////////////
  // monitor
  ////////////////////
  always @(negedge clk)
  begin : monitor
    int                   in_flight;
    logic [3:0]           lanes;
    logic [3:0]           want_mask;
    pkt_op_e              want_op;
    logic [data_w-1:0]    want_data;
    exp_rsp_t             head;
    if (!reset)
    begin
      // slots still held in the buffer
      in_flight = pkts_seen - rsps_seen - (rsp_valid ? 1 : 0);
      if (in_flight > max_outstanding_p)
      begin
        $display("more than %0d packets outstanding at %0t", max_outstanding_p, $time);
        errors++;
      end
      if (in_flight == max_outstanding_p)
      begin
        if (cmd_ready)
        begin
          $display("cmd_ready high with every tag in use at %0t", $time);
          errors++;
        end
        else
          saw_full = 1'b1;
      end
      if ((cmd_valid && cmd_ready) != (pkt_valid && pkt_ready))
      begin
        $display("command and packet did not transfer together at %0t", $time);
        errors++;
      end

      if (pkt_valid && pkt_ready)
      begin
        lanes     = lane_mask(cmd_size, cmd_addr[1:0]);
        want_op   = packet_op(cmd_write, lanes);
        want_mask = cmd_write ? lanes : {2'b00, cmd_addr[1:0]};
        if (pkt_op !== want_op)
          report_mismatch("pkt_op", 32'(pkt_op), 32'(want_op));
        if (pkt_mask !== want_mask)
          report_mismatch("pkt_mask", 32'(pkt_mask), 32'(want_mask));
        if (pkt_x !== route_coord(cmd_addr, tile_x_lsb))
          report_mismatch("pkt_x", 32'(pkt_x), 32'(route_coord(cmd_addr, tile_x_lsb)));
        if (pkt_y !== route_coord(cmd_addr, tile_y_lsb))
          report_mismatch("pkt_y", 32'(pkt_y), 32'(route_coord(cmd_addr, tile_y_lsb)));
        if (pkt_epa !== epa_w'(cmd_addr >> 2))
          report_mismatch("pkt_epa", 32'(pkt_epa), 32'(epa_w'(cmd_addr >> 2)));
        if (cmd_write && pkt_data !== cmd_data)
          report_mismatch("pkt_data", pkt_data, cmd_data);
        if (int'(pkt_tag) >= max_outstanding_p)
          report_mismatch("pkt_tag range", 32'(pkt_tag), 32'(max_outstanding_p - 1));
        for (int i = 0; i < pend_q.size(); i++)
        begin
          if (pend_q[i] == pkt_tag)
            report_mismatch("pkt_tag already pending", 32'(pkt_tag), 32'(pend_q[i]));
        end
        head.write = cmd_write;
        head.size  = cmd_size;
        head.addr  = cmd_addr;
        head.tag   = pkt_tag;
        head.got   = 1'b0;
        head.data  = '0;
        exp_q.push_back(head);
        pend_q.push_back(pkt_tag);
        pkts_seen++;
      end

      if (rsp_valid && rsp_ready)
      begin
        if (exp_q.size() == 0)
        begin
          $display("response at %0t with no command waiting for one", $time);
          errors++;
        end
        else
        begin
          head = exp_q.pop_front();
          if (!head.got)
          begin
            $display("response at %0t before the network returned its tag", $time);
            errors++;
          end
          want_data = head.write ? '0 : narrow_load(head.size, head.data);
          if (rsp_write !== head.write)
            report_mismatch("rsp_write", 32'(rsp_write), 32'(head.write));
          if (rsp_size !== head.size)
            report_mismatch("rsp_size", 32'(rsp_size), 32'(head.size));
          if (rsp_addr !== head.addr)
            report_mismatch("rsp_addr", rsp_addr, head.addr);
          if (rsp_data !== want_data)
            report_mismatch("rsp_data", rsp_data, want_data);
        end
        rsps_seen++;
      end
    end
  end

  ////////////////////
  // command stimulus
  ////////////////////
  initial
  begin : stimulus
    logic [31:0] r;
    logic [1:0]  size_code;
    int          gap;
    int          waited;
    logic        taken;
    stim_seed = 32'he454_4296;
    net_seed  = xorshift32(32'he454_4296 ^ 32'h5a5a_5a5a);
    errors    = 0;
    pkts_seen = 0;
    rsps_seen = 0;
    saw_full  = 1'b0;
    timed_out = 1'b0;
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_size  = size_4;
    cmd_addr  = '0;
    cmd_data  = '0;

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    if (pkt_valid !== 1'b0 || rsp_valid !== 1'b0)
    begin
      $display("pkt_valid or rsp_valid high right after reset");
      errors++;
    end
    if (pkt_ready && cmd_ready !== 1'b1)
    begin
      $display("cmd_ready low right after reset with every slot free");
      errors++;
    end
    @(posedge clk);
    #1;

    for (int n = 0; n < num_cmds && !timed_out; n++)
    begin
      r         = roll(stim_seed);
      size_code = 2'(r[9:2] % 8'd3);
      gap       = r[12] ? int'(r[14:13]) : 0;
      repeat (gap)
      begin
        @(posedge clk);
        #1;
      end
      cmd_write    = r[0];
      cmd_size     = msg_size_e'(size_code);
      cmd_addr     = roll(stim_seed);
      cmd_addr[31] = r[1];
      cmd_data     = roll(stim_seed);
      cmd_valid    = 1'b1;

      taken  = 1'b0;
      waited = 0;
      while (!taken && !timed_out)
      begin
        @(negedge clk);
        if (cmd_ready)
          taken = 1'b1;
        else if (waited == accept_wait)
        begin
          $display("timeout: command %0d not accepted in %0d cycles", n, accept_wait);
          timed_out = 1'b1;
        end
        waited++;
      end
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
    end

    waited = 0;
    while (rsps_seen < pkts_seen && !timed_out)
    begin
      @(posedge clk);
      if (waited == drain_wait)
      begin
        $display("timeout: %0d responses still missing", pkts_seen - rsps_seen);
        timed_out = 1'b1;
      end
      waited++;
    end

    if (!timed_out && rsps_seen != num_cmds)
    begin
      $display("%0d responses for %0d commands", rsps_seen, num_cmds);
      errors++;
    end
    if (!saw_full)
    begin
      $display("cmd_ready was never seen low with every tag in use");
      errors++;
    end

    $display("errors: %0d, commands: %0d, responses: %0d", errors, pkts_seen, rsps_seen);
    if (errors == 0 && !timed_out)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+test
hw/bridge_pkg.sv
hw/tag_alloc_if.sv
hw/resp_entry_if.sv
hw/cmd_issuer.sv
hw/reorder_buffer.sv
hw/resp_builder.sv
hw/mem_to_mesh_bridge.sv
test/tb_mem_to_mesh_bridge.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_mem_to_mesh_bridge
OUTSTANDING ?= 4
FILE_LIST   ?= all.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(FILE_LIST) $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP OUTSTANDING FILE_LIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gmax_outstanding_p=$(OUTSTANDING) \
	  -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
